//--- list.f
+incdir+design
design/rv_pkg.sv
design/exec_unit.sv
design/hart_ctrl.sv
design/fetch_unit.sv
design/load_store_unit.sv
design/mem_arbiter.sv
design/unified_mem.sv
design/rv_subsys_top.sv
bench/tb_rv_model.sv
bench/tb_rv_subsys.sv

//--- Bender.yml
package:
  name: rv_subsys

sources:
  - include_dirs:
      - design
    files:
      - design/rv_pkg.sv
      - design/exec_unit.sv
      - design/hart_ctrl.sv
      - design/fetch_unit.sv
      - design/load_store_unit.sv
      - design/mem_arbiter.sv
      - design/unified_mem.sv
      - design/rv_subsys_top.sv
  - target: test
    include_dirs:
      - design
    files:
      - bench/tb_rv_model.sv
      - bench/tb_rv_subsys.sv

//--- bench/tb_rv_subsys.sv
`include "rv_params.svh"

module tb_rv_subsys;
	timeunit 1ns;
	timeprecision 1ps;
	import rv_pkg::*;

	localparam int CLK_PERIOD = 8;
	localparam int N_PROGS = 4;
	localparam int PROG_LEN = 60;
	localparam int DATA_BASE = 256; // Byte address 0x400.
	localparam int DATA_WORDS = 32;
	localparam int SCRATCH_BASE = 400;
	localparam int SCRATCH_WORDS = 8;
	localparam int HALT_LIMIT = PROG_LEN * 40;
	localparam int WATCHDOG_CYCLES = N_PROGS * PROG_LEN * 40 + 2000;

	logic clk, arst_n, run;
	logic host_req, host_we, host_ack;
	addr_t host_addr;
	bmask_t host_bmask;
	word_t host_wdata, host_rdata;
	logic retire_valid, halted;
	addr_t retire_pc;
	reg_idx_t retire_rd;
	word_t retire_wdata;

	int errors;
	int retire_idx;

	rv_subsys_top rv_subsys_top_i (.*);

	tb_rv_model #(
		.DATA_BASE(DATA_BASE),
		.DATA_WORDS(DATA_WORDS)
	) model_i ();

	always #(CLK_PERIOD / 2) clk = ~clk;

	task automatic check_word(input word_t got, input word_t exp, input string what);
		if (got !== exp) begin
			errors++;
			$display("mismatch at %0t: %s is %08h, expected %08h", $time, what, got, exp);
		end
	endtask

	task automatic check_reg(input reg_idx_t got, input reg_idx_t exp, input string what);
		if (got !== exp) begin
			errors++;
			$display("mismatch at %0t: %s is x%0d, expected x%0d", $time, what, got, exp);
		end
	endtask

	task automatic check_addr(input addr_t got, input addr_t exp, input string what);
		if (got !== exp) begin
			errors++;
			$display("mismatch at %0t: %s is %08h, expected %08h", $time, what, got, exp);
		end
	endtask

	// Retirements are compared in program order against the model trace.
	always @(negedge clk) begin
		if (arst_n && retire_valid) begin
			if (retire_idx >= model_i.exp_count) begin
				errors++;
				$display("the hart retired more instructions than the model, extra pc %08h",
					retire_pc);
			end else begin
				check_addr(retire_pc, model_i.exp_pc[retire_idx], $sformatf("retire %0d pc", retire_idx));
				check_reg(retire_rd, model_i.exp_rd[retire_idx], $sformatf("retire %0d rd", retire_idx));
				check_word(retire_wdata, model_i.exp_wdata[retire_idx],
					$sformatf("retire %0d wdata", retire_idx));
			end
			retire_idx++;
		end
	end

	task automatic apply_reset();
		@(posedge clk);
		arst_n <= 1'b0;
		repeat (2) @(posedge clk);
		arst_n <= 1'b1;
		@(negedge clk);
		if (halted || retire_valid || host_ack) begin
			errors++;
			$display("outputs are not idle after reset");
		end
	endtask

	// One four-phase transaction on the host port.
	task automatic host_access(input logic we, input int w, input bmask_t mask,
			input word_t wdata, output word_t rdata);
		@(posedge clk);
		host_req <= 1'b1;
		host_we <= we;
		host_addr <= addr_t'(w * 4);
		host_bmask <= mask;
		host_wdata <= wdata;
		do @(negedge clk); while (!host_ack);
		rdata = host_rdata;
		@(posedge clk);
		host_req <= 1'b0;
		do @(negedge clk); while (host_ack);
	endtask

	task automatic compare_region(input int first, input int count);
		word_t got;
		int i;
		for (i = first; i < first + count; i++) begin
			host_access(1'b0, i, 4'b1111, '0, got);
			check_word(got, model_i.mem[i], $sformatf("memory word %0d", i));
		end
	endtask

	task automatic load_image();
		word_t val, old_word;
		bmask_t mask;
		int i, w, b;
		for (i = 0; i < PROG_LEN; i++) host_access(1'b1, i, 4'b1111, model_i.mem[i], old_word);
		for (i = DATA_BASE; i < DATA_BASE + DATA_WORDS; i++)
			host_access(1'b1, i, 4'b1111, model_i.mem[i], old_word);
		for (i = 0; i < 8; i++) begin
			w = DATA_BASE + model_i.rnd(DATA_WORDS);
			val = model_i.rnd_word();
			mask = bmask_t'(model_i.rnd(16));
			host_access(1'b1, w, mask, val, old_word);
			for (b = 0; b < 4; b++)
				if (mask[b]) model_i.mem[w][b * 8 +: 8] = val[b * 8 +: 8]; // Lanes outside mask kept.
		end
		compare_region(DATA_BASE, DATA_WORDS);
	endtask

	task automatic wait_halt(input int limit);
		int n;
		n = 0;
		while (!halted && n < limit) begin
			@(negedge clk);
			n++;
		end
		if (!halted) begin
			errors++;
			$display("the hart did not halt within %0d cycles", limit);
		end
	endtask

	// Host writes to an unused region while the hart runs.
	task automatic host_traffic();
		word_t val, got;
		int k, w;
		for (k = 0; k < SCRATCH_WORDS; k++) begin
			repeat (model_i.rnd(20)) @(posedge clk);
			w = SCRATCH_BASE + k;
			val = model_i.rnd_word();
			model_i.mem[w] = val;
			host_access(1'b1, w, 4'b1111, val, got);
			host_access(1'b0, w, 4'b1111, '0, got);
			check_word(got, val, $sformatf("host read of word %0d during run", w));
		end
	endtask

	task automatic run_program(input bit use_mem, input bit use_ctl, input bit busy_host);
		apply_reset();
		model_i.gen_program(PROG_LEN, use_mem, use_ctl);
		load_image();
		model_i.run_model();
		retire_idx = 0;
		@(posedge clk);
		run <= 1'b1;
		@(posedge clk);
		run <= 1'b0;
		if (busy_host) begin
			fork
				wait_halt(HALT_LIMIT);
				host_traffic();
			join
		end else begin
			wait_halt(HALT_LIMIT);
		end
		repeat (2) @(negedge clk);
		if (halted && retire_idx < model_i.exp_count) begin
			errors++;
			$display("the hart halted after %0d retirements, the model retired %0d",
				retire_idx, model_i.exp_count);
		end
		compare_region(DATA_BASE, DATA_WORDS);
		if (busy_host) compare_region(SCRATCH_BASE, SCRATCH_WORDS);
		if (!halted) begin
			errors++;
			$display("halted is low at the end of the program");
		end
	endtask

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clk);
		$display("watchdog expired after %0d cycles with %0d errors", WATCHDOG_CYCLES, errors);
		$display("SIMULATION FAILED");
		$finish;
	end

	initial begin
		int p;
		clk = 1'b0;
		arst_n = 1'b0;
		run = 1'b0;
		host_req = 1'b0;
		host_we = 1'b0;
		host_addr = '0;
		host_bmask = '0;
		host_wdata = '0;
		errors = 0;
		retire_idx = 0;
		// ALU only, then loads and stores, then control flow, then all with host traffic.
		for (p = 0; p < N_PROGS; p++) run_program(p[0], p[1], p == N_PROGS - 1);
		$display("errors: %0d", errors);
		if (errors == 0) $display("SIMULATION PASSED");
		else $display("SIMULATION FAILED");
		$finish;
	end

endmodule

//--- bench/tb_rv_model.sv
`include "rv_params.svh"

module tb_rv_model #(
	parameter int DATA_BASE = 256,
	parameter int DATA_WORDS = 32
);
	timeunit 1ns;
	timeprecision 1ps;
	import rv_pkg::*;

	localparam int MAX_TRACE = 4096;
	localparam opcode_t OP_R = 7'b0110011;
	localparam opcode_t OP_I = 7'b0010011;
	localparam opcode_t OP_LUI = 7'b0110111;
	localparam opcode_t OP_AUIPC = 7'b0010111;
	localparam opcode_t OP_LOAD = 7'b0000011;
	localparam opcode_t OP_STORE = 7'b0100011;
	localparam opcode_t OP_BRANCH = 7'b1100011;
	localparam opcode_t OP_JAL = 7'b1101111;
	localparam opcode_t OP_JALR = 7'b1100111;
	localparam word_t EBREAK = 32'h0010_0073;

	integer seed = 32'hcc3b69ce;

	word_t mem [`RV_MEM_WORDS]; // Architectural memory image.
	word_t regs [32];
	addr_t exp_pc [MAX_TRACE];
	reg_idx_t exp_rd [MAX_TRACE];
	word_t exp_wdata [MAX_TRACE];
	int exp_count;

	function automatic int rnd(input int n);
		return $unsigned($random(seed)) % n;
	endfunction

	function automatic word_t rnd_word();
		return $random(seed);
	endfunction

	function automatic word_t enc_r(input logic [6:0] f7, input reg_idx_t rs2,
			input reg_idx_t rs1, input func3_t f3, input reg_idx_t rd);
		return {f7, rs2, rs1, f3, rd, OP_R};
	endfunction

	function automatic word_t enc_i(input logic [11:0] imm, input reg_idx_t rs1,
			input func3_t f3, input reg_idx_t rd, input opcode_t op);
		return {imm, rs1, f3, rd, op};
	endfunction

	function automatic word_t enc_s(input logic [11:0] imm, input reg_idx_t rs2,
			input reg_idx_t rs1, input func3_t f3);
		return {imm[11:5], rs2, rs1, f3, imm[4:0], OP_STORE};
	endfunction

	function automatic word_t enc_b(input logic [12:0] imm, input reg_idx_t rs2,
			input reg_idx_t rs1, input func3_t f3);
		return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], OP_BRANCH};
	endfunction

	function automatic word_t enc_j(input logic [20:0] imm, input reg_idx_t rd);
		return {imm[20], imm[10:1], imm[11], imm[19:12], rd, OP_JAL};
	endfunction

	// Offset into the data region, aligned to the access size.
	function automatic logic [11:0] align(input int off, input func3_t f3);
		case (f3[1:0])
			2'b00: return 12'(off);
			2'b01: return 12'(off) & 12'hffe;
			default: return 12'(off) & 12'hffc;
		endcase
	endfunction

	function automatic word_t alu(input func3_t f3, input word_t a, input word_t b,
			input logic sub, input logic arith);
		case (f3)
			3'b000: return sub ? a - b : a + b;
			3'b001: return a << b[4:0];
			3'b010: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
			3'b011: return (a < b) ? 32'd1 : 32'd0;
			3'b100: return a ^ b;
			3'b101: begin
				if (arith) return $signed(a) >>> b[4:0];
				return a >> b[4:0];
			end
			3'b110: return a | b;
			default: return a & b;
		endcase
	endfunction

	task automatic gen_program(input int n, input bit use_mem, input bit use_ctl);
		int i, k, kind;
		reg_idx_t rd, rs1, rs2;
		func3_t f3;
		logic [6:0] f7;
		word_t val;
		for (i = 0; i < DATA_WORDS; i++) mem[DATA_BASE + i] = rnd_word();
		mem[0] = enc_i(12'(DATA_BASE * 4), 5'd0, 3'b000, 5'd1, OP_I); // x1 is the data pointer.
		for (i = 2; i < 16; i++) begin
			val = rnd_word();
			if (val[0]) mem[i - 1] = enc_i(val[31:20], 5'd0, 3'b000, reg_idx_t'(i), OP_I);
			else mem[i - 1] = {val[31:12], reg_idx_t'(i), OP_LUI};
		end
		for (i = 15; i < n - 1; i++) begin
			kind = rnd(4);
			if (use_mem && rnd(3) == 0) kind = 4 + rnd(2);
			if (use_ctl && rnd(3) == 0) kind = 6 + rnd(3);
			rd = reg_idx_t'(rnd(15) + 1);
			if (rd == 5'd1) rd = 5'd0;
			rs1 = reg_idx_t'(rnd(16));
			rs2 = reg_idx_t'(rnd(16));
			f3 = func3_t'(rnd(8));
			val = rnd_word();
			k = 1 + rnd(4);
			if (i + k > n - 1) k = n - 1 - i; // Forward targets only.
			f7 = ((f3 == 3'b000 || f3 == 3'b101) && val[0]) ? 7'h20 : 7'h00;
			case (kind)
				0: mem[i] = enc_r(f7, rs2, rs1, f3, rd);
				1: begin
					if (f3 == 3'b001) val[31:25] = 7'h00;
					if (f3 == 3'b101) val[31:25] = {1'b0, val[30], 5'b0};
					mem[i] = enc_i(val[31:20], rs1, f3, rd, OP_I);
				end
				2: mem[i] = {val[31:12], rd, OP_LUI};
				3: mem[i] = {val[31:12], rd, OP_AUIPC};
				4: begin
					f3 = func3_t'(rnd(5));
					if (f3 > 3'd2) f3 = f3 + 3'd1; // LBU and LHU.
					mem[i] = enc_i(align(rnd(DATA_WORDS * 4), f3), 5'd1, f3, rd, OP_LOAD);
				end
				5: begin
					f3 = func3_t'(rnd(3));
					mem[i] = enc_s(align(rnd(DATA_WORDS * 4), f3), rs2, 5'd1, f3);
				end
				6: begin
					f3 = func3_t'(rnd(6));
					if (f3 > 3'd1) f3 = f3 + 3'd2;
					mem[i] = enc_b(13'(k * 4), rs2, rs1, f3);
				end
				7: mem[i] = enc_j(21'(k * 4), rd);
				default: mem[i] = enc_i(12'((i + k) * 4 + rnd(2)), 5'd0, 3'b000, rd, OP_JALR);
			endcase
		end
		mem[n - 1] = EBREAK;
	endtask

	task automatic run_model();
		addr_t pc, npc, ea;
		word_t ins, a, b, imm, res, w;
		reg_idx_t rd;
		func3_t f3;
		logic wen, taken;
		int idx;
		for (idx = 0; idx < 32; idx++) regs[idx] = '0;
		pc = `RV_RESET_PC;
		exp_count = 0;
		ins = mem[(pc >> 2) % `RV_MEM_WORDS];
		while (ins != EBREAK && exp_count < MAX_TRACE) begin
			rd = ins[11:7];
			f3 = ins[14:12];
			a = regs[ins[19:15]];
			b = regs[ins[24:20]];
			imm = {{20{ins[31]}}, ins[31:20]};
			wen = 1'b1;
			res = '0;
			npc = pc + 32'd4;
			case (ins[6:0])
				OP_R: res = alu(f3, a, b, ins[30], ins[30]);
				OP_I: res = alu(f3, a, imm, 1'b0, ins[30]);
				OP_LUI: res = {ins[31:12], 12'b0};
				OP_AUIPC: res = pc + {ins[31:12], 12'b0};
				OP_LOAD: begin
					ea = a + imm;
					w = mem[(ea >> 2) % `RV_MEM_WORDS] >> (8 * ea[1:0]);
					case (f3)
						3'b000: res = {{24{w[7]}}, w[7:0]};
						3'b001: res = {{16{w[15]}}, w[15:0]};
						3'b100: res = {24'b0, w[7:0]};
						3'b101: res = {16'b0, w[15:0]};
						default: res = w;
					endcase
				end
				OP_STORE: begin
					wen = 1'b0;
					ea = a + {{20{ins[31]}}, ins[31:25], ins[11:7]};
					idx = (ea >> 2) % `RV_MEM_WORDS;
					case (f3)
						3'b000: mem[idx][8 * ea[1:0] +: 8] = b[7:0];
						3'b001: mem[idx][8 * ea[1:0] +: 16] = b[15:0];
						default: mem[idx] = b;
					endcase
				end
				OP_BRANCH: begin
					wen = 1'b0;
					case (f3)
						3'b000: taken = (a == b);
						3'b001: taken = (a != b);
						3'b100: taken = ($signed(a) < $signed(b));
						3'b101: taken = ($signed(a) >= $signed(b));
						3'b110: taken = (a < b);
						default: taken = (a >= b);
					endcase
					if (taken)
						npc = pc + {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
				end
				OP_JAL: begin
					res = pc + 32'd4;
					npc = pc + {{11{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
				end
				OP_JALR: begin
					res = pc + 32'd4;
					npc = (a + imm) & 32'hffff_fffe;
				end
				default: wen = 1'b0;
			endcase
			if (!wen || rd == 5'd0) begin
				rd = '0; // No register write is reported as x0.
				res = '0;
			end else begin
				regs[rd] = res;
			end
			exp_pc[exp_count] = pc;
			exp_rd[exp_count] = rd;
			exp_wdata[exp_count] = res;
			exp_count++;
			pc = npc;
			ins = mem[(pc >> 2) % `RV_MEM_WORDS];
		end
	endtask

endmodule

//--- design/rv_subsys_top.sv
module rv_subsys_top (
	input logic clk,
	input logic arst_n,
	input logic run,
	input logic host_req,
	input logic host_we,
	input rv_pkg::addr_t host_addr,
	input rv_pkg::bmask_t host_bmask,
	input rv_pkg::word_t host_wdata,
	output logic host_ack,
	output rv_pkg::word_t host_rdata,
	output logic retire_valid,
	output rv_pkg::addr_t retire_pc,
	output rv_pkg::reg_idx_t retire_rd,
	output rv_pkg::word_t retire_wdata,
	output logic halted
);
	import rv_pkg::*;

	addr_t pc, next_pc, mem_addr;
	addr_t f_addr, l_addr, m_addr;
	word_t instr, fetched, rs1_val, rs2_val, rd_data;
	word_t load_data, mem_wdata, l_wdata, m_wdata, m_rdata;
	reg_idx_t rs1, rs2, rd;
	func3_t mem_func3;
	bmask_t l_bmask, m_bmask;
	logic fetch_start, fetch_done, ls_start, ls_done;
	logic rd_wen, mem_ren, mem_wen, is_halt;
	logic f_req, f_ack, l_req, l_we, l_ack, m_req, m_we, m_ack;

	hart_ctrl hart_ctrl_i (
		.instr_in(fetched),
		.*
	);

	exec_unit exec_unit_i (.*);

	fetch_unit fetch_unit_i (
		.start(fetch_start),
		.done(fetch_done),
		.instr(fetched),
		.req(f_req),
		.addr(f_addr),
		.ack(f_ack),
		.rdata(host_rdata),
		.*
	);

	load_store_unit load_store_unit_i (
		.start(ls_start),
		.ren(mem_ren),
		.wen(mem_wen),
		.addr(mem_addr),
		.func3(mem_func3),
		.wdata(mem_wdata),
		.done(ls_done),
		.req(l_req),
		.we(l_we),
		.maddr(l_addr),
		.bmask(l_bmask),
		.mwdata(l_wdata),
		.ack(l_ack),
		.rdata(host_rdata),
		.*
	);

	mem_arbiter mem_arbiter_i (
		.h_req(host_req),
		.h_we(host_we),
		.h_addr(host_addr),
		.h_bmask(host_bmask),
		.h_wdata(host_wdata),
		.h_ack(host_ack),
		.rdata(host_rdata), // Shared by all three requesters.
		.*
	);

	unified_mem unified_mem_i (
		.req(m_req),
		.we(m_we),
		.addr(m_addr),
		.bmask(m_bmask),
		.wdata(m_wdata),
		.ack(m_ack),
		.rdata(m_rdata),
		.*
	);

endmodule

//--- design/unified_mem.sv
`include "rv_params.svh"

module unified_mem (
	input logic clk,
	input logic arst_n,
	input logic req,
	input logic we,
	input rv_pkg::addr_t addr,
	input rv_pkg::bmask_t bmask,
	input rv_pkg::word_t wdata,
	output logic ack,
	output rv_pkg::word_t rdata
);
	import rv_pkg::*;

	localparam int IDX_W = $clog2(`RV_MEM_WORDS);

	word_t mem [`RV_MEM_WORDS];
	logic [IDX_W-1:0] idx;
	logic accept;

	assign idx = addr[IDX_W+1:2];
	assign accept = req && !ack; // First cycle of a request.

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) ack <= 1'b0;
		else ack <= req;
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			for (int b = 0; b < 4; b++) begin
				if (we && bmask[b]) mem[idx][b*8 +: 8] <= wdata[b*8 +: 8];
			end
			rdata <= mem[idx]; // Old word on a write.
		end
	end

endmodule

//--- design/mem_arbiter.sv
module mem_arbiter (
	input logic clk,
	input logic arst_n,
	input logic h_req,
	input logic h_we,
	input rv_pkg::addr_t h_addr,
	input rv_pkg::bmask_t h_bmask,
	input rv_pkg::word_t h_wdata,
	output logic h_ack,
	input logic l_req,
	input logic l_we,
	input rv_pkg::addr_t l_addr,
	input rv_pkg::bmask_t l_bmask,
	input rv_pkg::word_t l_wdata,
	output logic l_ack,
	input logic f_req,
	input rv_pkg::addr_t f_addr,
	output logic f_ack,
	output rv_pkg::word_t rdata,
	output logic m_req,
	output logic m_we,
	output rv_pkg::addr_t m_addr,
	output rv_pkg::bmask_t m_bmask,
	output rv_pkg::word_t m_wdata,
	input logic m_ack,
	input rv_pkg::word_t m_rdata
);
	import rv_pkg::*;

	localparam bmask_t FETCH_MASK = 4'b1111;

	logic [2:0] grant; // Host, load/store, fetch.

	always_comb begin
		if (grant[2]) begin
			m_req = h_req;
			m_we = h_we;
			m_addr = h_addr;
			m_bmask = h_bmask;
			m_wdata = h_wdata;
		end else if (grant[1]) begin
			m_req = l_req;
			m_we = l_we;
			m_addr = l_addr;
			m_bmask = l_bmask;
			m_wdata = l_wdata;
		end else begin
			m_req = grant[0] && f_req;
			m_we = 1'b0;
			m_addr = f_addr;
			m_bmask = FETCH_MASK;
			m_wdata = '0;
		end
	end

	assign h_ack = grant[2] && m_ack;
	assign l_ack = grant[1] && m_ack;
	assign f_ack = grant[0] && m_ack;
	assign rdata = m_rdata;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			grant <= '0;
		end else if (grant == '0) begin
			if (!m_ack) begin // m_req is already low here.
				if (h_req) grant <= 3'b100;
				else if (l_req) grant <= 3'b010;
				else if (f_req) grant <= 3'b001;
			end
		end else if (!m_req && !m_ack) begin
			grant <= '0; // Phase 4 done.
		end
	end

	// Ownership never passes straight from one requester to another.
	a_grant: assert property (@(posedge clk) disable iff (!arst_n)
		$onehot0(grant) && (grant == $past(grant) || grant == '0 || $past(grant) == '0));

endmodule

//--- design/load_store_unit.sv
module load_store_unit (
	input logic clk,
	input logic arst_n,
	input logic start,
	input logic ren,
	input logic wen,
	input rv_pkg::addr_t addr,
	input rv_pkg::func3_t func3,
	input rv_pkg::word_t wdata,
	output logic done,
	output rv_pkg::word_t load_data,
	output logic req,
	output logic we,
	output rv_pkg::addr_t maddr,
	output rv_pkg::bmask_t bmask,
	output rv_pkg::word_t mwdata,
	input logic ack,
	input rv_pkg::word_t rdata
);
	import rv_pkg::*;

	bmask_t lane_mask;
	word_t lane_wdata, lane_rdata, ext_data;
	func3_t ls_func3;
	logic [1:0] ls_off;
	logic draining;

	always_comb begin
		case (func3[1:0])
			2'b00: lane_mask = 4'b0001 << addr[1:0];
			2'b01: lane_mask = 4'b0011 << addr[1:0];
			default: lane_mask = 4'b1111;
		endcase
	end

	assign lane_wdata = wdata << {addr[1:0], 3'b000};
	assign lane_rdata = rdata >> {ls_off, 3'b000}; // Addressed byte to lane 0.

	always_comb begin
		case (ls_func3)
			3'b000: ext_data = {{24{lane_rdata[7]}}, lane_rdata[7:0]};
			3'b001: ext_data = {{16{lane_rdata[15]}}, lane_rdata[15:0]};
			3'b100: ext_data = {24'b0, lane_rdata[7:0]};
			3'b101: ext_data = {16'b0, lane_rdata[15:0]};
			default: ext_data = lane_rdata;
		endcase
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			req <= 1'b0;
			draining <= 1'b0;
			done <= 1'b0;
		end else begin
			done <= 1'b0;
			if (start && !req && !draining) begin
				req <= 1'b1;
			end else if (req && ack) begin
				req <= 1'b0;
				draining <= 1'b1;
			end else if (draining && !ack) begin
				draining <= 1'b0;
				done <= 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (start) begin
			we <= wen;
			maddr <= {addr[31:2], 2'b00};
			bmask <= ren ? 4'b1111 : lane_mask; // Reads fetch the whole word.
			mwdata <= lane_wdata;
			ls_func3 <= func3;
			ls_off <= addr[1:0];
		end
		if (req && ack) load_data <= ext_data;
	end

endmodule

//--- design/fetch_unit.sv
module fetch_unit (
	input logic clk,
	input logic arst_n,
	input logic start,
	input rv_pkg::addr_t pc,
	output logic done,
	output rv_pkg::word_t instr,
	output logic req,
	output rv_pkg::addr_t addr,
	input logic ack,
	input rv_pkg::word_t rdata
);
	import rv_pkg::*;

	localparam addr_t WORD_ALIGN = 32'hffff_fffc;

	logic draining;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			req <= 1'b0;
			draining <= 1'b0;
			done <= 1'b0;
		end else begin
			done <= 1'b0;
			if (start && !req && !draining) begin
				req <= 1'b1;
			end else if (req && ack) begin
				req <= 1'b0; // Word captured below.
				draining <= 1'b1;
			end else if (draining && !ack) begin
				draining <= 1'b0;
				done <= 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (start) addr <= pc & WORD_ALIGN;
		if (req && ack) instr <= rdata;
	end

	a_req_after_ack: assert property (@(posedge clk) disable iff (!arst_n)
		$rose(req) |-> !$past(ack));

endmodule

//--- design/hart_ctrl.sv
`include "rv_params.svh"

module hart_ctrl (
	input logic clk,
	input logic arst_n,
	input logic run,
	output logic fetch_start,
	input logic fetch_done,
	input rv_pkg::word_t instr_in,
	output rv_pkg::addr_t pc,
	output rv_pkg::word_t instr,
	input rv_pkg::reg_idx_t rs1,
	input rv_pkg::reg_idx_t rs2,
	output rv_pkg::word_t rs1_val,
	output rv_pkg::word_t rs2_val,
	input rv_pkg::reg_idx_t rd,
	input logic rd_wen,
	input rv_pkg::word_t rd_data,
	input logic mem_ren,
	input logic mem_wen,
	input logic is_halt,
	input rv_pkg::addr_t next_pc,
	output logic ls_start,
	input logic ls_done,
	output logic retire_valid,
	output rv_pkg::addr_t retire_pc,
	output rv_pkg::reg_idx_t retire_rd,
	output rv_pkg::word_t retire_wdata,
	output logic halted
);
	import rv_pkg::*;

	hart_state_t state;
	word_t regs [32];
	logic wr_en;

	assign wr_en = (state == WB) && rd_wen && (rd != '0);
	assign rs1_val = (rs1 == '0) ? '0 : regs[rs1]; // x0 reads zero.
	assign rs2_val = (rs2 == '0) ? '0 : regs[rs2];

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state <= IDLE;
			pc <= `RV_RESET_PC;
			fetch_start <= 1'b0;
			ls_start <= 1'b0;
		end else begin
			fetch_start <= 1'b0;
			ls_start <= 1'b0;
			case (state)
				IDLE: if (run) begin
					pc <= `RV_RESET_PC;
					fetch_start <= 1'b1;
					state <= FETCH;
				end
				FETCH: if (fetch_done) state <= EXEC;
				EXEC: if (is_halt) begin
					state <= HALT;
				end else if (mem_ren || mem_wen) begin
					ls_start <= 1'b1;
					state <= MEM;
				end else begin
					state <= WB;
				end
				MEM: if (ls_done) state <= WB;
				WB: begin
					pc <= next_pc;
					fetch_start <= 1'b1;
					state <= FETCH;
				end
				default: ; // Stays halted until reset.
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == FETCH && fetch_done) instr <= instr_in;
		if (wr_en) regs[rd] <= rd_data;
	end

	assign retire_valid = (state == WB);
	assign retire_pc = pc;
	assign retire_rd = wr_en ? rd : '0;
	assign retire_wdata = wr_en ? rd_data : '0;
	assign halted = (state == HALT);

	// WB lasts one cycle and follows EXEC or a completed memory access.
	a_retire_wb: assert property (@(posedge clk) disable iff (!arst_n)
		retire_valid |-> state == WB && $past(state) inside {EXEC, MEM});

endmodule

//--- design/exec_unit.sv
module exec_unit (
	input rv_pkg::word_t instr,
	input rv_pkg::addr_t pc,
	input rv_pkg::word_t rs1_val,
	input rv_pkg::word_t rs2_val,
	input rv_pkg::word_t load_data,
	output rv_pkg::reg_idx_t rs1,
	output rv_pkg::reg_idx_t rs2,
	output rv_pkg::reg_idx_t rd,
	output logic rd_wen,
	output rv_pkg::word_t rd_data,
	output logic mem_ren,
	output logic mem_wen,
	output rv_pkg::addr_t mem_addr,
	output rv_pkg::func3_t mem_func3,
	output rv_pkg::word_t mem_wdata,
	output rv_pkg::addr_t next_pc,
	output logic is_halt
);
	import rv_pkg::*;

	localparam opcode_t OP_R = 7'b0110011;
	localparam opcode_t OP_I = 7'b0010011;
	localparam opcode_t OP_LUI = 7'b0110111;
	localparam opcode_t OP_AUIPC = 7'b0010111;
	localparam opcode_t OP_LOAD = 7'b0000011;
	localparam opcode_t OP_STORE = 7'b0100011;
	localparam opcode_t OP_BRANCH = 7'b1100011;
	localparam opcode_t OP_JAL = 7'b1101111;
	localparam opcode_t OP_JALR = 7'b1100111;
	localparam word_t EBREAK = 32'h0010_0073;

	opcode_t opcode;
	func3_t func3;
	word_t imm_i, imm_s, imm_b, imm_u, imm_j;
	word_t alu_b, alu_res, sra_res;
	addr_t snpc;
	logic alt;
	logic take;

	assign opcode = instr[6:0];
	assign func3 = instr[14:12];
	assign rd = instr[11:7];
	assign rs1 = instr[19:15];
	assign rs2 = instr[24:20];

	assign imm_i = {{20{instr[31]}}, instr[31:20]};
	assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
	assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
	assign imm_u = {instr[31:12], 12'b0};
	assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

	assign snpc = pc + 32'd4;
	assign alu_b = (opcode == OP_R) ? rs2_val : imm_i;
	assign alt = instr[30] && ((opcode == OP_R) || (func3 == 3'b101)); // SUB, SRA, SRAI.
	assign sra_res = $signed(rs1_val) >>> alu_b[4:0];

	always_comb begin
		case (func3)
			3'b000: alu_res = alt ? rs1_val - alu_b : rs1_val + alu_b;
			3'b001: alu_res = rs1_val << alu_b[4:0];
			3'b010: alu_res = {31'b0, $signed(rs1_val) < $signed(alu_b)};
			3'b011: alu_res = {31'b0, rs1_val < alu_b};
			3'b100: alu_res = rs1_val ^ alu_b;
			3'b101: alu_res = alt ? sra_res : rs1_val >> alu_b[4:0];
			3'b110: alu_res = rs1_val | alu_b;
			default: alu_res = rs1_val & alu_b;
		endcase
	end

	always_comb begin
		case (func3)
			3'b000: take = (rs1_val == rs2_val);
			3'b001: take = (rs1_val != rs2_val);
			3'b100: take = ($signed(rs1_val) < $signed(rs2_val));
			3'b101: take = ($signed(rs1_val) >= $signed(rs2_val));
			3'b110: take = (rs1_val < rs2_val);
			3'b111: take = (rs1_val >= rs2_val);
			default: take = 1'b0;
		endcase
	end

	always_comb begin
		rd_wen = 1'b0;
		rd_data = alu_res;
		mem_ren = 1'b0;
		mem_wen = 1'b0;
		next_pc = snpc;
		case (opcode)
			OP_R, OP_I: rd_wen = 1'b1;
			OP_LUI: begin
				rd_wen = 1'b1;
				rd_data = imm_u;
			end
			OP_AUIPC: begin
				rd_wen = 1'b1;
				rd_data = pc + imm_u;
			end
			OP_LOAD: begin
				rd_wen = 1'b1;
				rd_data = load_data;
				mem_ren = 1'b1;
			end
			OP_STORE: mem_wen = 1'b1;
			OP_BRANCH: if (take) next_pc = pc + imm_b;
			OP_JAL: begin
				rd_wen = 1'b1;
				rd_data = snpc;
				next_pc = pc + imm_j;
			end
			OP_JALR: begin
				rd_wen = 1'b1;
				rd_data = snpc;
				next_pc = (rs1_val + imm_i) & ~32'd1;
			end
			default: ; // Unknown opcodes retire as a no-op.
		endcase
	end

	assign mem_addr = rs1_val + ((opcode == OP_STORE) ? imm_s : imm_i);
	assign mem_func3 = func3;
	assign mem_wdata = rs2_val;
	assign is_halt = (instr == EBREAK);

	a_mem_excl: assert final (!(mem_ren && mem_wen))
		else $error("load and store decoded from one instruction");

endmodule

//--- design/rv_pkg.sv
package rv_pkg;

	typedef logic [31:0] word_t;
	typedef logic [31:0] addr_t; // Byte address.
	typedef logic [4:0] reg_idx_t;
	typedef logic [6:0] opcode_t;
	typedef logic [2:0] func3_t;
	typedef logic [3:0] bmask_t; // One bit per byte lane.

	typedef enum logic [2:0] {
		IDLE,
		FETCH,
		EXEC,
		MEM,
		WB,
		HALT
	} hart_state_t;

endpackage

//--- design/rv_params.svh
`ifndef RV_PARAMS_SVH
`define RV_PARAMS_SVH

`define RV_MEM_WORDS 1024 // Depth in 32-bit words.
`define RV_RESET_PC 32'h0000_0000

`endif
